//--- all.f
verilog/mipsPkg.sv
verilog/pipeReg.sv
verilog/decoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/aluUnit.sv
verilog/memCtrl.sv
verilog/datapath.sv
sim/tbDatapath.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbDatapath \
    -f all.f -Mdir obj_dir -o simDatapath

out=$(./obj_dir/simDatapath 2>&1) || true
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

//--- sim/tbDatapath.sv
`timescale 1ns/10ps

module tbDatapath import mipsPkg::*; ();

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [31:0] MARKER   = 32'h0000_00FC;  // last store of every program
    localparam logic [31:0] POISON   = 32'h0000_00F8;
    localparam int          WAIT_MAX = 200;

    logic        clk;
    logic        rstN_i;
    logic        dCacheStall_i;
    logic        instEn_o, memEn_o;
    logic [31:0] instAddr_o, instr_i, memAddr_o, memRdata_i, memWdata_o;
    logic [3:0]  memWen_o;

    logic [31:0] rom [64];
    logic [7:0]  ram [256];
    logic [31:0] romOff;
    logic [31:0] storeCount;
    logic [31:0] fetchHolds;
    logic [31:0] firstRun [12];
    logic [1:0]  stallLeft;
    logic        stallRandom;
    int          romTop;

    datapath #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rstN_i(rstN_i), .instAddr_o(instAddr_o), .instEn_o(instEn_o),
        .instr_i(instr_i), .memEn_o(memEn_o), .memAddr_o(memAddr_o),
        .memRdata_i(memRdata_i), .memWen_o(memWen_o), .memWdata_o(memWdata_o),
        .dCacheStall_i(dCacheStall_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign romOff  = instAddr_o - RESET_PC;
    assign instr_i = (romOff[31:8] == 24'd0) ? rom[romOff[7:2]] : 32'h0;  // nop past the ROM
    assign memRdata_i = {ram[{memAddr_o[7:2], 2'd3}], ram[{memAddr_o[7:2], 2'd2}],
                         ram[{memAddr_o[7:2], 2'd1}], ram[{memAddr_o[7:2], 2'd0}]};

    function automatic logic [7:0] fillByte(logic [7:0] a);
        return a * 8'd37 + 8'h5B;
    endfunction

    function automatic logic [31:0] fillWord(logic [7:0] a);
        return {fillByte(a + 8'd3), fillByte(a + 8'd2), fillByte(a + 8'd1), fillByte(a)};
    endfunction

    function automatic logic [31:0] ramWord(logic [7:0] a);
        return {ram[a + 8'd3], ram[a + 8'd2], ram[a + 8'd1], ram[a]};
    endfunction

    // data RAM refills while reset is held
    always @(posedge clk) begin
        if (!rstN_i) begin
            for (int a = 0; a < 256; a++)
                ram[8'(a)] <= fillByte(8'(a));
            storeCount <= 32'd0;
        end else if (memWen_o != 4'b0000) begin
            for (int l = 0; l < 4; l++)
                if (memWen_o[l])
                    ram[{memAddr_o[7:2], 2'(l)}] <= memWdata_o[8*l +: 8];
            storeCount <= storeCount + 32'd1;
        end
    end

    // cycles with fetch held
    always @(posedge clk) begin
        if (!rstN_i)
            fetchHolds <= 32'd0;
        else if (!instEn_o)
            fetchHolds <= fetchHolds + 32'd1;
    end

    initial begin
        dCacheStall_i <= 1'b0;
        stallLeft     <= 2'd0;
        forever begin
            @(posedge clk);
            if (stallLeft != 2'd0) begin
                dCacheStall_i <= 1'b1;
                stallLeft     <= stallLeft - 2'd1;
            end else begin
                dCacheStall_i <= 1'b0;
                if (stallRandom)
                    stallLeft <= 2'($urandom_range(3, 0));  // burst of 0..3 cycles
            end
        end
    end

    task automatic failRun(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            failRun($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkWen(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp)
            failRun($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] rOp(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                         logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iOp(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jOp(int idx);
        return {OP_J, 26'((RESET_PC >> 2) + 32'(idx))};
    endfunction

    task automatic put(logic [31:0] w);
        rom[6'(romTop)] = w;
        romTop++;
    endtask

    task automatic clearRom();
        for (int i = 0; i < 64; i++)
            rom[6'(i)] = 32'h0;
        romTop = 0;
    endtask

    // bus stays idle and PC at its reset value through a 2-cycle reset
    task automatic resetDut();
        @(posedge clk);
        rstN_i <= 1'b0;
        for (int c = 0; c < 3; c++) begin
            if (c == 2) begin
                @(posedge clk);
                rstN_i <= 1'b1;
            end
            @(negedge clk);
            checkWen("memWen_o", memWen_o, 4'b0000);
            checkWord("memEn_o", {31'b0, memEn_o}, 32'h0);
            checkWord("instAddr_o", instAddr_o, RESET_PC);
        end
    endtask

    task automatic waitStore(output logic [31:0] addr, output logic [3:0] wen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (memWen_o == 4'b0000 && cycles < WAIT_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (memWen_o == 4'b0000) begin
            failRun("timed out waiting for a store from the DUT");
        end else begin
            checkWord("memEn_o", {31'b0, memEn_o}, 32'h1);
            addr = memAddr_o;
            wen  = memWen_o;
        end
    endtask

    task automatic runToMarker();
        logic [31:0] addr;
        logic [3:0]  wen;
        int          stores;
        addr   = 32'h0;
        stores = 0;
        while (addr != MARKER && stores < 64) begin
            waitStore(addr, wen);
            stores++;
        end
        if (addr != MARKER)
            failRun("program never reached its final store");
        else
            @(negedge clk);  // marker store has landed
    endtask

    task automatic putAluProgram();
        put(iOp(OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        put(iOp(OP_ADDIU, 5'd2, 5'd1, 16'hFFFB));  // rs from M
        put(rOp(FN_ADDU, 5'd3, 5'd1, 5'd2));        // W and M
        put(rOp(FN_SUBU, 5'd4, 5'd3, 5'd1));
        put(rOp(FN_AND, 5'd5, 5'd4, 5'd3));
        put(iOp(OP_LUI, 5'd6, 5'd0, 16'h8001));
        put(iOp(OP_ORI, 5'd7, 5'd6, 16'hF00F));
        put(rOp(FN_SLT, 5'd8, 5'd7, 5'd5));
        put(rOp(FN_SLT, 5'd9, 5'd5, 5'd7));
        put(rOp(FN_OR, 5'd10, 5'd9, 5'd8));
        put(rOp(FN_SUBU, 5'd11, 5'd0, 5'd10));
        for (int r = 11; r >= 1; r--)
            put(iOp(OP_SW, 5'(r), 5'd0, 16'(4 * (r - 1))));
        put(iOp(OP_SW, 5'd0, 5'd0, MARKER[15:0]));
    endtask

    task automatic testAluChain(input logic stalled);
        logic [31:0] e [12];
        clearRom();
        putAluProgram();
        resetDut();
        stallRandom = stalled;
        runToMarker();
        stallRandom = 1'b0;
        e[0]  = 32'h0;
        e[1]  = 32'h0000_1234;
        e[2]  = e[1] + 32'hFFFF_FFFB;
        e[3]  = e[1] + e[2];
        e[4]  = e[3] - e[1];
        e[5]  = e[4] & e[3];
        e[6]  = 32'h8001_0000;
        e[7]  = e[6] | 32'h0000_F00F;  // ori zero-extends
        e[8]  = ($signed(e[7]) < $signed(e[5])) ? 32'd1 : 32'd0;
        e[9]  = ($signed(e[5]) < $signed(e[7])) ? 32'd1 : 32'd0;
        e[10] = e[9] | e[8];
        e[11] = 32'd0 - e[10];
        for (int r = 1; r <= 11; r++) begin
            if (stalled) begin
                checkWord($sformatf("ram[%02h]", 4 * (r - 1)), ramWord(8'(4 * (r - 1))),
                          firstRun[4'(r)]);
            end else begin
                checkWord($sformatf("ram[%02h]", 4 * (r - 1)), ramWord(8'(4 * (r - 1))),
                          e[4'(r)]);
                firstRun[4'(r)] = ramWord(8'(4 * (r - 1)));
            end
        end
        checkWord("storeCount", storeCount, 32'd12);
    endtask

    task automatic testLoadUse();
        clearRom();
        put(iOp(OP_ADDIU, 5'd1, 5'd0, 16'h0077));
        put(iOp(OP_LW, 5'd2, 5'd0, 16'h0040));
        put(rOp(FN_ADDU, 5'd3, 5'd2, 5'd1));  // needs the bubble
        put(iOp(OP_SW, 5'd3, 5'd0, 16'h0080));
        put(iOp(OP_LW, 5'd4, 5'd0, 16'h0044));
        put(rOp(FN_ADDU, 5'd5, 5'd4, 5'd4));
        put(iOp(OP_SW, 5'd5, 5'd0, 16'h0084));
        put(iOp(OP_LW, 5'd6, 5'd0, 16'h0048));
        put(iOp(OP_SW, 5'd6, 5'd0, 16'h0088));
        put(iOp(OP_SW, 5'd0, 5'd0, MARKER[15:0]));
        resetDut();
        runToMarker();
        checkWord("ram[80]", ramWord(8'h80), fillWord(8'h40) + 32'h77);
        checkWord("ram[84]", ramWord(8'h84), fillWord(8'h44) + fillWord(8'h44));
        checkWord("ram[88]", ramWord(8'h88), fillWord(8'h48));
        checkWord("storeCount", storeCount, 32'd4);
        checkWord("instEn_o low cycles", fetchHolds, 32'd3);  // one per load-use pair
    endtask

    task automatic testByteLanes();
        logic [31:0] v [4];
        logic [31:0] addr;
        logic [3:0]  wen;
        logic [3:0]  expWen;
        v[0] = 32'h0000_01A5;
        v[1] = 32'h0000_003C;
        v[2] = 32'h0000_07E1;
        v[3] = 32'h0000_0258;
        clearRom();
        for (int k = 0; k < 4; k++)
            put(iOp(OP_ADDIU, 5'(k + 1), 5'd0, v[2'(k)][15:0]));
        for (int k = 0; k < 4; k++)
            put(iOp(OP_SB, 5'(k + 1), 5'd0, 16'(32'h60 + k)));
        put(iOp(OP_LW, 5'd5, 5'd0, 16'h0060));
        for (int k = 0; k < 4; k++)
            put(iOp(OP_LBU, 5'(k + 6), 5'd0, 16'(32'h60 + k)));
        for (int r = 5; r <= 9; r++)
            put(iOp(OP_SW, 5'(r), 5'd0, 16'(32'hB0 + 4 * (r - 5))));
        put(iOp(OP_SW, 5'd0, 5'd0, MARKER[15:0]));
        resetDut();
        for (int k = 0; k < 4; k++) begin
            expWen = 4'b0001 << k;  // one lane per sb
            waitStore(addr, wen);
            checkWen("memWen_o", wen, expWen);
            checkWord("memAddr_o", addr, 32'h60 + 32'(k));
        end
        runToMarker();
        checkWord("ram[b0]", ramWord(8'hB0), {v[3][7:0], v[2][7:0], v[1][7:0], v[0][7:0]});
        for (int k = 0; k < 4; k++)
            checkWord($sformatf("ram[%02h]", 32'hB4 + 4 * k), ramWord(8'(32'hB4 + 4 * k)),
                      {24'h0, v[2'(k)][7:0]});
        checkWord("storeCount", storeCount, 32'd10);
    endtask

    task automatic testBranches();
        clearRom();
        put(iOp(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        put(iOp(OP_ADDIU, 5'd3, 5'd0, 16'd7));
        put(iOp(OP_ADDIU, 5'd9, 5'd0, 16'h0099));
        put(iOp(OP_ADDIU, 5'd2, 5'd0, 16'd5));
        put(iOp(OP_BEQ, 5'd2, 5'd1, 16'd2));  // taken with rt forwarded from M
        put(iOp(OP_SW, 5'd9, 5'd0, POISON[15:0]));
        put(iOp(OP_SW, 5'd9, 5'd0, POISON[15:0]));
        put(iOp(OP_SW, 5'd1, 5'd0, 16'h0090));
        put(iOp(OP_BNE, 5'd2, 5'd1, 16'd2));
        put(iOp(OP_SW, 5'd3, 5'd0, 16'h0094));
        put(iOp(OP_BEQ, 5'd3, 5'd1, 16'd2));
        put(iOp(OP_SW, 5'd2, 5'd0, 16'h0098));
        put(iOp(OP_BNE, 5'd3, 5'd1, 16'd2));  // taken
        put(iOp(OP_SW, 5'd9, 5'd0, POISON[15:0]));
        put(iOp(OP_SW, 5'd9, 5'd0, POISON[15:0]));
        put(iOp(OP_SW, 5'd3, 5'd0, 16'h009C));
        put(jOp(romTop + 3));
        put(iOp(OP_SW, 5'd9, 5'd0, POISON[15:0]));
        put(iOp(OP_SW, 5'd9, 5'd0, POISON[15:0]));
        put(iOp(OP_SW, 5'd1, 5'd0, 16'h00A0));
        put(iOp(OP_SW, 5'd0, 5'd0, MARKER[15:0]));
        resetDut();
        runToMarker();
        checkWord("ram[90]", ramWord(8'h90), 32'd5);
        checkWord("ram[94]", ramWord(8'h94), 32'd7);
        checkWord("ram[98]", ramWord(8'h98), 32'd5);
        checkWord("ram[9c]", ramWord(8'h9C), 32'd7);
        checkWord("ram[a0]", ramWord(8'hA0), 32'd5);
        checkWord("ram[f8]", ramWord(POISON[7:0]), fillWord(POISON[7:0]));
        checkWord("storeCount", storeCount, 32'd6);
    endtask

    initial begin
        rstN_i      <= 1'b0;
        stallRandom = 1'b0;
        void'($urandom(13502));
        testAluChain(1'b0);
        testLoadUse();
        testByteLanes();
        testBranches();
        testAluChain(1'b1);  // same program under random cache stalls
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog/datapath.sv
`timescale 1ns/10ps

module datapath import mipsPkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN_i,
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    input  logic [31:0] instr_i,
    output logic        memEn_o,
    output logic [31:0] memAddr_o,
    input  logic [31:0] memRdata_i,
    output logic [3:0]  memWen_o,
    output logic [31:0] memWdata_o,
    input  logic        dCacheStall_i
);

    logic [31:0] pcF, pcPlus4F, pcNext;
    logic        stallF, flushD, flushE, freeze;
    ifIdT        ifIdD, ifIdQ;
    ctrlT        ctrlD;
    logic [4:0]  rsD, rtD, rdD;
    logic [31:0] immD, rd1D, rd2D, pcPlus4D, jumpTargetD;
    idExT        idExD, idExQ;
    fwdSelE      fwdA, fwdB;
    logic [31:0] srcA, rtValE, srcB, aluOutE, branchTargetE;
    logic        branchTaken;
    exMemT       exMemD, exMemQ;
    logic [3:0]  wenM;
    logic [31:0] loadValM, resultM;
    memWbT       memWbD, memWbQ;

    hazardUnit hazard (
        .idEx_i(idExQ), .exMem_i(exMemQ), .memWb_i(memWbQ),
        .rsD_i(rsD), .rtD_i(rtD),
        .branchTaken_i(branchTaken), .jumpD_i(ctrlD.jump), .dCacheStall_i(dCacheStall_i),
        .fwdA_o(fwdA), .fwdB_o(fwdB),
        .stallF_o(stallF), .flushD_o(flushD), .flushE_o(flushE), .freeze_o(freeze)
    );

    // IF
    assign pcPlus4F = pcF + 32'd4;

    always_comb begin
        if (branchTaken)
            pcNext = branchTargetE;  // older instr wins over j in ID
        else if (ctrlD.jump)
            pcNext = jumpTargetD;
        else
            pcNext = pcPlus4F;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            pcF <= RESET_PC;
        else if (!stallF)
            pcF <= pcNext;
    end

    assign instAddr_o = pcF;
    assign instEn_o   = ~stallF;
    assign ifIdD      = '{pc: pcF, instr: instr_i};

    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallF), .flush_i(flushD),
        .d_i(ifIdD), .q_o(ifIdQ)
    );

    // ID
    assign rsD = ifIdQ.instr[25:21];
    assign rtD = ifIdQ.instr[20:16];
    assign rdD = ifIdQ.instr[15:11];

    decoder dec (.instr_i(ifIdQ.instr), .ctrl_o(ctrlD), .imm_o(immD));

    regFile rf (
        .clk(clk), .rstN_i(rstN_i), .we_i(memWbQ.regWrite & ~freeze),
        .ra1_i(rsD), .ra2_i(rtD), .wa_i(memWbQ.dst), .wd_i(memWbQ.result),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    assign pcPlus4D    = ifIdQ.pc + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], ifIdQ.instr[25:0], 2'b00};
    assign idExD = '{ctrl: ctrlD, pc: ifIdQ.pc, rsVal: rd1D, rtVal: rd2D, imm: immD,
                     rs: rsD, rt: rtD, dst: ctrlD.regDstRt ? rtD : rdD};

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(freeze), .flush_i(flushE),
        .d_i(idExD), .q_o(idExQ)
    );

    // EX
    always_comb begin
        case (fwdA)
            FWD_M:   srcA = resultM;
            FWD_W:   srcA = memWbQ.result;
            default: srcA = idExQ.rsVal;
        endcase
        case (fwdB)
            FWD_M:   rtValE = resultM;
            FWD_W:   rtValE = memWbQ.result;
            default: rtValE = idExQ.rtVal;
        endcase
    end

    assign srcB = idExQ.ctrl.aluSrcImm ? idExQ.imm : rtValE;

    aluUnit alu (.a_i(srcA), .b_i(srcB), .op_i(idExQ.ctrl.aluOp), .y_o(aluOutE));

    assign branchTaken   = idExQ.ctrl.branch & ((srcA == rtValE) ^ idExQ.ctrl.branchNe);
    assign branchTargetE = idExQ.pc + 32'd4 + {idExQ.imm[29:0], 2'b00};
    assign exMemD = '{ctrl: idExQ.ctrl, aluOut: aluOutE, storeVal: rtValE, dst: idExQ.dst};

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(freeze), .flush_i(1'b0),
        .d_i(exMemD), .q_o(exMemQ)
    );

    // MEM
    memCtrl mc (
        .exMem_i(exMemQ), .rdata_i(memRdata_i),
        .wen_o(wenM), .wdata_o(memWdata_o), .loadVal_o(loadValM), .en_o(memEn_o)
    );

    assign memAddr_o = exMemQ.aluOut;
    assign memWen_o  = wenM & {4{~freeze}};  // store lands once, when the stall lifts
    assign resultM   = exMemQ.ctrl.memRead ? loadValM : exMemQ.aluOut;
    assign memWbD    = '{regWrite: exMemQ.ctrl.regWrite, result: resultM, dst: exMemQ.dst};

    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(freeze), .flush_i(1'b0),
        .d_i(memWbD), .q_o(memWbQ)
    );

    redirectChk: assert property (@(posedge clk) disable iff (!rstN_i)
        branchTaken && !freeze |=> pcF == $past(branchTargetE))
        else $error("taken branch did not redirect fetch");

endmodule

//--- verilog/memCtrl.sv
`timescale 1ns/10ps

module memCtrl import mipsPkg::*; (
    input  exMemT       exMem_i,
    input  logic [31:0] rdata_i,
    output logic [3:0]  wen_o,
    output logic [31:0] wdata_o,
    output logic [31:0] loadVal_o,
    output logic        en_o
);

    logic [1:0] byteOff;
    logic [7:0] byteVal;

    assign byteOff = exMem_i.aluOut[1:0];
    assign en_o    = exMem_i.ctrl.memRead | exMem_i.ctrl.memWrite;

    always_comb begin
        wen_o = 4'b0000;
        if (exMem_i.ctrl.memWrite)
            wen_o = exMem_i.ctrl.memByte ? (4'b0001 << byteOff) : 4'b1111;
    end

    // sb puts the byte on every lane
    assign wdata_o = exMem_i.ctrl.memByte ? {4{exMem_i.storeVal[7:0]}} : exMem_i.storeVal;

    assign byteVal   = rdata_i[8*byteOff +: 8];
    assign loadVal_o = exMem_i.ctrl.memByte ? {24'b0, byteVal} : rdata_i;

    always_comb begin
        if (en_o && !exMem_i.ctrl.memByte)
            assert (byteOff == 2'b00)
                else $error("unaligned word access at %h", exMem_i.aluOut);
    end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/10ps

module aluUnit import mipsPkg::*; (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  aluOpE       op_i,
    output logic [31:0] y_o
);

    logic [31:0] diff;

    assign diff = a_i - b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = diff;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_SLT: begin
                // signed compare from sign bits and the difference
                if (a_i[31] != b_i[31])
                    y_o = {31'b0, a_i[31]};
                else
                    y_o = {31'b0, diff[31]};
            end
            ALU_LUI: y_o = {b_i[15:0], 16'b0};
            default: y_o = 32'b0;
        endcase
    end

endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import mipsPkg::*; (
    input  idExT       idEx_i,
    input  exMemT      exMem_i,
    input  memWbT      memWb_i,
    input  logic [4:0] rsD_i,
    input  logic [4:0] rtD_i,
    input  logic       branchTaken_i,
    input  logic       jumpD_i,
    input  logic       dCacheStall_i,
    output fwdSelE     fwdA_o,
    output fwdSelE     fwdB_o,
    output logic       stallF_o,
    output logic       flushD_o,
    output logic       flushE_o,
    output logic       freeze_o
);

    logic loadUse;

    function automatic fwdSelE pickSrc(input logic [4:0] src, input exMemT m, input memWbT w);
        if (src != 5'd0 && m.ctrl.regWrite && m.dst == src)
            return FWD_M;  // younger result wins
        if (src != 5'd0 && w.regWrite && w.dst == src)
            return FWD_W;
        return FWD_RF;
    endfunction

    assign fwdA_o = pickSrc(idEx_i.rs, exMem_i, memWb_i);
    assign fwdB_o = pickSrc(idEx_i.rt, exMem_i, memWb_i);

    // j reads no registers
    assign loadUse = idEx_i.ctrl.memRead && !jumpD_i && idEx_i.dst != 5'd0
                     && (idEx_i.dst == rsD_i || idEx_i.dst == rtD_i);

    assign freeze_o = dCacheStall_i;
    assign stallF_o = loadUse | dCacheStall_i;
    assign flushD_o = (branchTaken_i | jumpD_i) & ~dCacheStall_i;
    assign flushE_o = (branchTaken_i | loadUse) & ~dCacheStall_i;

    always_comb begin
        if (!freeze_o && (stallF_o || flushE_o))
            assert (idEx_i.ctrl.memRead || idEx_i.ctrl.branch)
                else $error("hold or flush without load or branch in EX");
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        we_i,
    input  logic [4:0]  ra1_i,
    input  logic [4:0]  ra2_i,
    input  logic [4:0]  wa_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'b0;
        end else if (we_i && wa_i != 5'd0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // W stage value reaches ID in the same cycle
    assign rd1_o = (ra1_i == 5'd0) ? 32'b0 :
                   (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? 32'b0 :
                   (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

//--- verilog/decoder.sv
`timescale 1ns/10ps

module decoder import mipsPkg::*; (
    input  logic [31:0] instr_i,
    output ctrlT        ctrl_o,
    output logic [31:0] imm_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    // only ori zero-extends
    assign imm_o = (opcode == OP_ORI) ? {16'b0, instr_i[15:0]}
                                      : {{16{instr_i[15]}}, instr_i[15:0]};

    always_comb begin
        ctrl_o = '0;  // unknown opcode is a nop
        case (opcode)
            OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    default: ctrl_o = '0;  // incl. sll $0 bubble
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.regDstRt  = 1'b1;
                ctrl_o.aluOp     = (opcode == OP_ORI) ? ALU_OR :
                                   (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
            end
            OP_LW, OP_LBU: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.memRead   = 1'b1;
                ctrl_o.memByte   = (opcode == OP_LBU);
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.regDstRt  = 1'b1;
            end
            OP_SW, OP_SB: begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.memByte   = (opcode == OP_SB);
                ctrl_o.aluSrcImm = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.branch   = 1'b1;
                ctrl_o.branchNe = (opcode == OP_BNE);
                ctrl_o.aluOp    = ALU_SUB;
            end
            OP_J: begin
                ctrl_o.jump = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

//--- verilog/pipeReg.sv
`timescale 1ns/10ps

module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // flush beats stall and loads an all-zero bubble
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i)
            q_o <= '0;
        else if (flush_i)
            q_o <= '0;
        else if (!stall_i)
            q_o <= d_i;
    end

endmodule

//--- verilog/mipsPkg.sv
package mipsPkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } aluOpE;

    // EX operand source
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_M  = 2'd1,
        FWD_W  = 2'd2
    } fwdSelE;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memByte;   // lbu / sb
        logic  branch;
        logic  branchNe;
        logic  jump;
        logic  aluSrcImm;
        logic  regDstRt;  // I-type writes rt
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] pc;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
    } idExT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] aluOut;
        logic [31:0] storeVal;
        logic [4:0]  dst;
    } exMemT;

    typedef struct packed {
        logic        regWrite;
        logic [31:0] result;
        logic [4:0]  dst;
    } memWbT;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

endpackage
